// ==== vanilla_front_pkg.sv ====
`default_nettype none

package vanilla_front_pkg;

  // Register index and major opcode
  typedef logic [4:0] reg_addr_t;
  typedef logic [6:0] opcode_t;

  // Position of a micro-op inside one expansion
  typedef logic [1:0] uop_idx_t;

  // R-type layout, msb first
  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    opcode_t    opcode;
  } instr_t;

  // Expanded micro-op, 36 bits
  typedef struct packed {
    instr_t   instr;
    logic     head;
    logic     tail;
    uop_idx_t index;
  } uop_t;

  // Decode result for the execute side, 38 bits
  typedef struct packed {
    uop_t uop;
    logic is_flwadd;
    logic illegal;
  } decoded_t;

  // custom-0 major opcode
  localparam opcode_t OPCODE_CUSTOM0 = 7'b0001011;

  // funct3 values inside custom-0
  localparam logic [2:0] FUNCT3_FLWADD4 = 3'b100;
  localparam logic [2:0] FUNCT3_FLWADD  = 3'b000;

  // Micro-ops per FLWADD4
  localparam int EXPAND_COUNT = 4;

  // Default instruction queue depth
  localparam int QUEUE_DEPTH = 2;

endpackage

`default_nettype wire

// ==== instr_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

module instr_queue #(
  parameter int depth_p = vanilla_front_pkg::QUEUE_DEPTH
) (
  input  wire                       clk_i,
  input  wire                       reset_i,
  input  wire                       flush_i,
  input  wire                       in_valid_i,
  output logic                      in_ready_o,
  input  wire vanilla_front_pkg::instr_t in_instr_i,
  output logic                      out_valid_o,
  input  wire                       out_ready_i,
  output vanilla_front_pkg::instr_t out_instr_o
);

  localparam int ptr_width_lp   = (depth_p > 1) ? $clog2(depth_p) : 1;
  localparam int count_width_lp = $clog2(depth_p + 1);

  vanilla_front_pkg::instr_t mem_r [depth_p];

  logic [ptr_width_lp-1:0]   wr_ptr_r, rd_ptr_r;
  logic [count_width_lp-1:0] count_r;
  logic push, pop;

  assign in_ready_o  = (count_r != count_width_lp'(depth_p));
  assign out_valid_o = (count_r != '0);
  assign out_instr_o = mem_r[rd_ptr_r];

  // Flush wins over any transfer in the same cycle
  assign push = in_valid_i & in_ready_o & ~flush_i;
  assign pop  = out_valid_o & out_ready_i & ~flush_i;

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push) begin
        wr_ptr_r <= (wr_ptr_r == ptr_width_lp'(depth_p - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (pop) begin
        rd_ptr_r <= (rd_ptr_r == ptr_width_lp'(depth_p - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  // Storage array
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_r[wr_ptr_r] <= in_instr_i;
    end
  end

endmodule

`default_nettype wire

// ==== macro_expander.sv ====
`timescale 1ns/100ps
`default_nettype none

module macro_expander (
  input  wire                       clk_i,
  input  wire                       reset_i,
  input  wire                       flush_i,
  input  wire                       in_valid_i,
  output logic                      in_ready_o,
  input  wire vanilla_front_pkg::instr_t in_instr_i,
  output logic                      out_valid_o,
  input  wire                       out_ready_i,
  output vanilla_front_pkg::uop_t   out_uop_o
);

  typedef enum logic {
    e_start,
    e_expand
  } expand_state_e;

  localparam vanilla_front_pkg::uop_idx_t last_idx_lp =
    vanilla_front_pkg::uop_idx_t'(vanilla_front_pkg::EXPAND_COUNT - 1);

  expand_state_e state_r, state_n;

  vanilla_front_pkg::reg_addr_t rd_r, rs1_r, rs2_r;
  vanilla_front_pkg::uop_idx_t  cnt_r, cnt_n;

  logic is_flwadd4;
  logic fire;
  logic capture;
  logic last;

  assign is_flwadd4 = (in_instr_i.opcode == vanilla_front_pkg::OPCODE_CUSTOM0)
                   && (in_instr_i.funct3 == vanilla_front_pkg::FUNCT3_FLWADD4);
  assign fire = out_valid_o & out_ready_i;
  assign last = (cnt_r == last_idx_lp);

  always_comb begin
    out_valid_o     = in_valid_i;
    in_ready_o      = 1'b0;
    out_uop_o       = '0;
    out_uop_o.instr = in_instr_i;
    state_n         = state_r;
    cnt_n           = cnt_r;
    capture         = 1'b0;

    case (state_r)
      e_start: begin
        if (is_flwadd4) begin
          // First micro-op comes straight from the live input, funct7 zeroed
          out_uop_o.instr.funct7 = '0;
          out_uop_o.instr.funct3 = vanilla_front_pkg::FUNCT3_FLWADD;
          out_uop_o.head         = 1'b1;
          if (fire) begin
            capture = 1'b1;
            cnt_n   = 2'd1;
            state_n = e_expand;
          end
        end else begin
          in_ready_o = out_ready_i;
        end
      end

      e_expand: begin
        out_uop_o.instr.funct7 = '0;
        out_uop_o.instr.rs2    = rs2_r;
        out_uop_o.instr.rs1    = rs1_r;
        out_uop_o.instr.funct3 = vanilla_front_pkg::FUNCT3_FLWADD;
        out_uop_o.instr.rd     = rd_r;
        out_uop_o.instr.opcode = vanilla_front_pkg::OPCODE_CUSTOM0;
        out_uop_o.tail         = last;
        out_uop_o.index        = cnt_r;
        // Macro-op leaves the queue with the tail
        in_ready_o = out_ready_i & last;
        if (fire) begin
          if (last) begin
            cnt_n   = '0;
            state_n = e_start;
          end else begin
            cnt_n = cnt_r + 1'b1;
          end
        end
      end

      default: begin
        state_n = e_start;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      state_r <= e_start;
      cnt_r   <= '0;
    end else begin
      state_r <= state_n;
      cnt_r   <= cnt_n;
    end
  end

  // Operand copies for the remaining micro-ops
  always_ff @(posedge clk_i) begin
    if (capture) begin
      rd_r  <= in_instr_i.rd + 5'd1;
      rs1_r <= in_instr_i.rs1;
      rs2_r <= in_instr_i.rs2;
    end else if (state_r == e_expand && fire && !last) begin
      rd_r <= rd_r + 5'd1;
    end
  end

endmodule

`default_nettype wire

// ==== micro_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module micro_decode (
  input  wire                         clk_i,
  input  wire                         reset_i,
  input  wire                         flush_i,
  input  wire                         in_valid_i,
  output logic                        in_ready_o,
  input  wire vanilla_front_pkg::uop_t in_uop_i,
  output logic                        out_valid_o,
  input  wire                         out_ready_i,
  output vanilla_front_pkg::decoded_t out_dec_o
);

  logic                        valid_r;
  vanilla_front_pkg::decoded_t dec_r;
  vanilla_front_pkg::decoded_t dec_n;

  logic is_custom0;
  logic is_flwadd;

  assign is_custom0 = (in_uop_i.instr.opcode == vanilla_front_pkg::OPCODE_CUSTOM0);
  assign is_flwadd  = is_custom0
                   && (in_uop_i.instr.funct3 == vanilla_front_pkg::FUNCT3_FLWADD);

  // Classify the incoming micro-op
  always_comb begin
    dec_n           = '0;
    dec_n.uop       = in_uop_i;
    dec_n.is_flwadd = is_flwadd;
    // Any other custom-0 funct3, including a leftover FLWADD4
    dec_n.illegal   = is_custom0 & ~is_flwadd;
  end

  // Stage can take a new entry when empty or draining this cycle
  assign in_ready_o = ~valid_r | out_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      valid_r <= 1'b0;
    end else if (in_ready_o) begin
      valid_r <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      dec_r <= dec_n;
    end
  end

  assign out_valid_o = valid_r;
  assign out_dec_o   = dec_r;

endmodule

`default_nettype wire

// ==== front_end_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module front_end_top #(
  parameter int queue_depth_p = vanilla_front_pkg::QUEUE_DEPTH
) (
  input  wire                          clk_i,
  input  wire                          reset_i,
  input  wire                          flush_i,
  input  wire                          in_valid_i,
  output logic                         in_ready_o,
  input  wire vanilla_front_pkg::instr_t in_instr_i,
  output logic                         out_valid_o,
  input  wire                          out_ready_i,
  output vanilla_front_pkg::decoded_t  out_dec_o
);

  // Queue to expander
  logic                      q_valid, q_ready;
  vanilla_front_pkg::instr_t q_instr;

  // Expander to decode
  logic                      x_valid, x_ready;
  vanilla_front_pkg::uop_t   x_uop;

  instr_queue #(
    .depth_p(queue_depth_p)
  ) queue (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .flush_i    (flush_i),
    .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o),
    .in_instr_i (in_instr_i),
    .out_valid_o(q_valid),
    .out_ready_i(q_ready),
    .out_instr_o(q_instr)
  );

  macro_expander expander (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .flush_i    (flush_i),
    .in_valid_i (q_valid),
    .in_ready_o (q_ready),
    .in_instr_i (q_instr),
    .out_valid_o(x_valid),
    .out_ready_i(x_ready),
    .out_uop_o  (x_uop)
  );

  micro_decode decode (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .flush_i    (flush_i),
    .in_valid_i (x_valid),
    .in_ready_o (x_ready),
    .in_uop_i   (x_uop),
    .out_valid_o(out_valid_o),
    .out_ready_i(out_ready_i),
    .out_dec_o  (out_dec_o)
  );

endmodule

`default_nettype wire

// ==== tb_front_end.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_front_end;

  localparam int wait_limit_lp = 200;

  // One expected output with its acceptance cycle
  typedef struct packed {
    vanilla_front_pkg::decoded_t dec;
    logic                        lat;
    logic [31:0]                 cycle;
  } model_entry_t;

  logic clk_i = 1'b0;
  logic reset_i, flush_i, in_valid_i, in_ready_o, out_valid_o, out_ready_i;
  vanilla_front_pkg::instr_t   in_instr_i;
  vanilla_front_pkg::decoded_t out_dec_o;

  model_entry_t                model_q[$];
  model_entry_t                exp_entry;
  vanilla_front_pkg::decoded_t prev_dec;
  logic        prev_valid = 1'b0;
  logic        prev_ready = 1'b0;
  logic        stall_en, lat_mode;
  logic [31:0] lfsr_state = 32'hc619c472;
  logic [31:0] cycle_count = '0;
  int          value_errors = 0;
  int          protocol_errors = 0;
  int          sequence_errors = 0;
  int          timeout_errors = 0;

  front_end_top #(
    .queue_depth_p(vanilla_front_pkg::QUEUE_DEPTH)
  ) DUT (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .flush_i    (flush_i),
    .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o),
    .in_instr_i (in_instr_i),
    .out_valid_o(out_valid_o),
    .out_ready_i(out_ready_i),
    .out_dec_o  (out_dec_o)
  );

  always #2 clk_i = ~clk_i;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] value;
    int          i;
    value = '0;
    for (i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  function automatic vanilla_front_pkg::instr_t make_ordinary();
    vanilla_front_pkg::instr_t ins;
    logic [31:0]               sel;
    ins = random_bits(32);
    sel = random_bits(2);
    case (sel[1:0])
      2'd0:    ins.opcode = 7'b0110011;
      2'd1:    ins.opcode = 7'b0010011;
      2'd2:    ins.opcode = 7'b0000011;
      default: ins.opcode = 7'b0100011;
    endcase
    return ins;
  endfunction

  function automatic vanilla_front_pkg::instr_t make_flwadd4(input logic [4:0] rd,
                                                             input logic [4:0] rs1,
                                                             input logic [4:0] rs2);
    vanilla_front_pkg::instr_t ins;
    ins = random_bits(32);
    ins.opcode = vanilla_front_pkg::OPCODE_CUSTOM0;
    ins.funct3 = vanilla_front_pkg::FUNCT3_FLWADD4;
    ins.rd     = rd;
    ins.rs1    = rs1;
    ins.rs2    = rs2;
    return ins;
  endfunction

  function automatic vanilla_front_pkg::instr_t make_unknown();
    vanilla_front_pkg::instr_t ins;
    ins = random_bits(32);
    ins.opcode = vanilla_front_pkg::OPCODE_CUSTOM0;
    // Steer away from 000 and 100
    if (ins.funct3[1:0] == 2'b00) begin
      ins.funct3[0] = 1'b1;
    end
    return ins;
  endfunction

  // Expected decode results for one accepted instruction
  function automatic void expect_instr(input vanilla_front_pkg::instr_t ins, input logic lat);
    model_entry_t e;
    int           k;
    e = '0;
    e.lat = lat;
    e.cycle = cycle_count;
    e.dec.uop.instr = ins;
    if (ins.opcode == vanilla_front_pkg::OPCODE_CUSTOM0
        && ins.funct3 == vanilla_front_pkg::FUNCT3_FLWADD4) begin
      for (k = 0; k < vanilla_front_pkg::EXPAND_COUNT; k++) begin
        e.dec.uop.instr.funct7 = '0;
        e.dec.uop.instr.funct3 = vanilla_front_pkg::FUNCT3_FLWADD;
        e.dec.uop.instr.rd     = ins.rd + 5'(k);
        e.dec.uop.head         = (k == 0);
        e.dec.uop.tail         = (k == vanilla_front_pkg::EXPAND_COUNT - 1);
        e.dec.uop.index        = 2'(k);
        e.dec.is_flwadd        = 1'b1;
        model_q.push_back(e);
      end
    end else begin
      e.dec.is_flwadd = (ins.opcode == vanilla_front_pkg::OPCODE_CUSTOM0)
                     && (ins.funct3 == vanilla_front_pkg::FUNCT3_FLWADD);
      e.dec.illegal   = (ins.opcode == vanilla_front_pkg::OPCODE_CUSTOM0) && !e.dec.is_flwadd;
      model_q.push_back(e);
    end
  endfunction

  // Output monitor and model bookkeeping
  always @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      model_q.delete();
      prev_valid = 1'b0;
    end else begin
      if (prev_valid && !prev_ready) begin
        assert (out_valid_o && out_dec_o == prev_dec) else begin
          protocol_errors++;
          $display("[ERROR] %0t: output moved while stalled", $time);
        end
      end
      if (out_valid_o && out_ready_i) begin
        if (model_q.size() == 0) begin
          value_errors++;
          $display("[ERROR] %0t: unexpected output %h", $time, out_dec_o);
        end else begin
          exp_entry = model_q.pop_front();
          assert (out_dec_o == exp_entry.dec) else begin
            value_errors++;
            $display("[ERROR] %0t: output %h, expected %h", $time, out_dec_o, exp_entry.dec);
          end
          if (exp_entry.lat) begin
            assert (cycle_count - exp_entry.cycle == 32'd2) else begin
              value_errors++;
              $display("[ERROR] %0t: latency %0d cycles, expected 2", $time,
                       cycle_count - exp_entry.cycle);
            end
          end
        end
      end
      if (in_valid_i && in_ready_o) begin
        expect_instr(in_instr_i, lat_mode);
      end
      prev_valid = out_valid_o;
      prev_ready = out_ready_i;
      prev_dec   = out_dec_o;
    end
    cycle_count = cycle_count + 1;
  end

  // Downstream ready with random stalls when enabled
  initial begin
    out_ready_i = 1'b1;
    forever begin
      @(posedge clk_i);
      out_ready_i <= stall_en ? (random_bits(2) != 0) : 1'b1;
    end
  end

  task automatic send_instr(input vanilla_front_pkg::instr_t ins);
    int waited;
    waited = 0;
    in_valid_i <= 1'b1;
    in_instr_i <= ins;
    @(posedge clk_i);
    while (!in_ready_o) begin
      waited++;
      if (waited > wait_limit_lp) begin
        timeout_errors++;
        $display("Timeout: the front end never accepted an instruction");
        break;
      end
      @(posedge clk_i);
    end
    in_valid_i <= 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge clk_i);
  endtask

  task automatic wait_head();
    int waited;
    waited = 0;
    @(posedge clk_i);
    while (!(out_valid_o && out_dec_o.uop.head)) begin
      waited++;
      if (waited > wait_limit_lp) begin
        timeout_errors++;
        $display("Timeout: no first micro-op reached the output");
        break;
      end
      @(posedge clk_i);
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    // The monitor has recorded the last acceptance by the next edge
    @(posedge clk_i);
    while (model_q.size() != 0 || out_valid_o) begin
      waited++;
      if (waited > wait_limit_lp) begin
        timeout_errors++;
        $display("Timeout: %0d expected outputs never arrived", model_q.size());
        break;
      end
      @(posedge clk_i);
    end
  endtask

  initial begin
    int          n;
    logic [31:0] pick;
    reset_i    = 1'b1;
    flush_i    = 1'b0;
    in_valid_i = 1'b0;
    in_instr_i = '0;
    stall_en   = 1'b0;
    lat_mode   = 1'b0;
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
    assert (!out_valid_o && in_ready_o) else begin
      sequence_errors++;
      $display("[ERROR] %0t: wrong valid or ready after reset", $time);
    end

    // Back-to-back ordinary stream with a fixed latency
    lat_mode <= 1'b1;
    for (n = 0; n < 8; n++) begin
      send_instr(make_ordinary());
    end
    lat_mode <= 1'b0;
    wait_drain();

    // rd wraps past 31
    send_instr(make_flwadd4(5'd30, 5'd7, 5'd12));
    wait_head();
    for (n = 0; n < 3; n++) begin
      @(posedge clk_i);
      assert (out_valid_o) else begin
        sequence_errors++;
        $display("[ERROR] %0t: gap inside an expansion", $time);
      end
    end
    wait_drain();

    send_instr(make_unknown());
    wait_drain();

    // Flush after the first micro-op has left
    send_instr(make_flwadd4(5'd9, 5'd1, 5'd2));
    send_instr(make_ordinary());
    wait_head();
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    idle(6);
    send_instr(make_flwadd4(5'd17, 5'd4, 5'd5));
    wait_drain();

    // Random mix under back-pressure
    stall_en <= 1'b1;
    for (n = 0; n < 80; n++) begin
      pick = random_bits(2);
      case (pick[1:0])
        2'd2: begin
          pick = random_bits(15);
          send_instr(make_flwadd4(pick[4:0], pick[9:5], pick[14:10]));
        end
        2'd3:    send_instr(make_unknown());
        default: send_instr(make_ordinary());
      endcase
      pick = random_bits(3);
      if (pick[2]) begin
        idle(int'(pick[1:0]) + 1);
      end
    end
    stall_en <= 1'b0;
    wait_drain();

    $display("Error counts: value %0d, protocol %0d, sequence %0d, timeout %0d",
             value_errors, protocol_errors, sequence_errors, timeout_errors);
    if (value_errors + protocol_errors + sequence_errors + timeout_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
vanilla_front_pkg.sv
instr_queue.sv
macro_expander.sv
micro_decode.sv
front_end_top.sv
tb_front_end.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_front_end -f verilog.f -o sim_front_end

./obj_dir/sim_front_end > sim.log 2>&1
cat sim.log

if grep -q "^all tests passed$" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
